//--- design/id_pipe_reg.sv
// fetch-to-decode register for valid, pc and pc_plus, held while the pipeline stalls
`timescale 1ns/1ps

module id_pipe_reg (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 stall,
	input  idu_pkg::fetch_info_t in_info,
	output idu_pkg::fetch_info_t out_info
);

	idu_pkg::fetch_info_t info_q;

	// load the fetch item unless decode is frozen
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			info_q <= '0;
		end else if (!stall) begin
			info_q <= in_info;
		end
	end

	assign out_info = info_q;

endmodule

//--- design/idu_pkg.sv
// shared widths, opcode and funct encodings and structs for the decode stage
package idu_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// major opcode, instruction bits 6 to 2
	typedef logic [4:0] opcode_t;

	localparam opcode_t op_lui    = 5'b01101;
	localparam opcode_t op_auipc  = 5'b00101;
	localparam opcode_t op_jal    = 5'b11011;
	localparam opcode_t op_jalr   = 5'b11001;
	localparam opcode_t op_branch = 5'b11000;
	localparam opcode_t op_load   = 5'b00000;
	localparam opcode_t op_store  = 5'b01000;
	localparam opcode_t op_imm    = 5'b00100;
	localparam opcode_t op_reg    = 5'b01100;
	localparam opcode_t op_fence  = 5'b00011;

	// funct3 of branches
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// funct3 of loads and stores
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// funct3 of alu ops, shared by imm and reg forms
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t alu_add  = 4'd0;
	localparam alu_op_t alu_sub  = 4'd1;
	localparam alu_op_t alu_sll  = 4'd2;
	localparam alu_op_t alu_slt  = 4'd3;
	localparam alu_op_t alu_sltu = 4'd4;
	localparam alu_op_t alu_xor  = 4'd5;
	localparam alu_op_t alu_srl  = 4'd6;
	localparam alu_op_t alu_sra  = 4'd7;
	localparam alu_op_t alu_or   = 4'd8;
	localparam alu_op_t alu_and  = 4'd9;
	localparam alu_op_t alu_seq  = 4'd10;
	localparam alu_op_t alu_sne  = 4'd11;
	localparam alu_op_t alu_sge  = 4'd12;
	localparam alu_op_t alu_sgeu = 4'd13;

	typedef logic [2:0] mem_size_t;

	localparam mem_size_t size_byte_s = 3'd0;
	localparam mem_size_t size_byte_u = 3'd1;
	localparam mem_size_t size_half_s = 3'd2;
	localparam mem_size_t size_half_u = 3'd3;
	localparam mem_size_t size_word   = 3'd4;

	// write-back source select
	localparam logic [1:0] wb_alu   = 2'd0;
	localparam logic [1:0] wb_upper = 2'd1;
	localparam logic [1:0] wb_link  = 2'd2;

	// addi x0,x0,0
	localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] pc_plus;
	} fetch_info_t;

	typedef struct packed {
		logic      rf_we;
		logic [1:0] wb_sel;
		logic      wb_from_mem;
		logic      alu_src_imm;
		alu_op_t   alu_op;
		logic      mem_we;
		logic      mem_re;
		mem_size_t mem_size;
		logic      branch;
		logic      jump;
		logic      jump_reg;
	} ex_ctrl_t;

	typedef struct packed {
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rd;
	} reg_idx_t;

endpackage

//--- design/idu_top.sv
// decode stage top, connects pipe register, instruction buffer, decoder, immediates and hazard
`timescale 1ns/1ps

module idu_top (
	input  logic                           clk,
	input  logic                           rstn,
	input  idu_pkg::fetch_info_t           if_info,
	input  logic                           imem_valid,
	input  logic [idu_pkg::xlen-1:0]       imem_data,
	input  logic                           stall,
	input  logic                           flush,
	input  logic                           ex_mem_re,
	input  logic [idu_pkg::reg_addr_w-1:0] ex_rd,
	output logic                           id_valid,
	output logic [idu_pkg::xlen-1:0]       id_pc,
	output logic [idu_pkg::xlen-1:0]       id_pc_plus,
	output logic [idu_pkg::xlen-1:0]       id_inst,
	output idu_pkg::reg_idx_t              id_regs,
	output idu_pkg::ex_ctrl_t              id_ctrl,
	output logic [idu_pkg::xlen-1:0]       id_imm,
	output logic                           hazard
);

	idu_pkg::fetch_info_t     slot;
	logic [idu_pkg::xlen-1:0] inst;
	logic                     inst_valid;
	logic                     uses_rs2;

	id_pipe_reg u_pipe_reg (
		.clk      (clk),
		.rstn     (rstn),
		.stall    (stall),
		.in_info  (if_info),
		.out_info (slot)
	);

	inst_buffer u_inst_buffer (
		.clk        (clk),
		.rstn       (rstn),
		.stall      (stall),
		.slot_valid (slot.valid),
		.imem_valid (imem_valid),
		.imem_data  (imem_data),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

	inst_decoder u_decoder (
		.slot_valid (slot.valid),
		.inst       (inst),
		.inst_valid (inst_valid),
		.flush      (flush),
		.ctrl       (id_ctrl),
		.regs       (id_regs),
		.out_inst   (id_inst),
		.out_valid  (id_valid),
		.uses_rs2   (uses_rs2)
	);

	imm_gen u_imm_gen (
		.inst (inst),
		.imm  (id_imm)
	);

	load_use_hazard u_hazard (
		.slot_valid (slot.valid),
		.inst_valid (inst_valid),
		.ex_mem_re  (ex_mem_re),
		.uses_rs2   (uses_rs2),
		.ex_rd      (ex_rd),
		.regs       (id_regs),
		.hazard     (hazard)
	);

	assign id_pc      = slot.pc;
	assign id_pc_plus = slot.pc_plus;

endmodule

//--- design/imm_gen.sv
// immediate generator, picks the format from the opcode and sign-extends from bit 31
`timescale 1ns/1ps

module imm_gen (
	input  logic [idu_pkg::xlen-1:0] inst,
	output logic [idu_pkg::xlen-1:0] imm
);

	idu_pkg::opcode_t         opcode;
	logic [idu_pkg::xlen-1:0] imm_i;
	logic [idu_pkg::xlen-1:0] imm_s;
	logic [idu_pkg::xlen-1:0] imm_b;
	logic [idu_pkg::xlen-1:0] imm_j;
	logic [idu_pkg::xlen-1:0] imm_u;

	assign opcode = inst[6:2];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};

	always_comb begin
		case (opcode)
			idu_pkg::op_jalr,
			idu_pkg::op_load,
			idu_pkg::op_imm:    imm = imm_i;
			idu_pkg::op_store:  imm = imm_s;
			idu_pkg::op_branch: imm = imm_b;
			idu_pkg::op_jal:    imm = imm_j;
			// lui, auipc and anything undefined
			default:            imm = imm_u;
		endcase
	end

endmodule

//--- design/inst_buffer.sv
// one-entry instruction buffer, replays the imem response captured when a stall begins
`timescale 1ns/1ps

module inst_buffer (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     stall,
	input  logic                     slot_valid,
	input  logic                     imem_valid,
	input  logic [idu_pkg::xlen-1:0] imem_data,
	output logic [idu_pkg::xlen-1:0] inst,
	output logic                     inst_valid
);

	logic                     held;
	logic                     capture;
	logic                     buf_en;
	logic [idu_pkg::xlen-1:0] buf_word;
	logic                     buf_valid;

	// the live word is only returned once, so grab it at the stall edge
	assign capture = slot_valid && imem_valid && stall && !held;
	assign buf_en  = !(held && stall);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			held <= 1'b0;
		end else if (capture) begin
			held <= 1'b1;
		end else if (held && !stall) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			buf_valid <= 1'b0;
		end else if (buf_en) begin
			buf_valid <= imem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (buf_en) begin
			buf_word <= imem_data;
		end
	end

	// replay while held, live response otherwise
	assign inst       = held ? buf_word  : imem_data;
	assign inst_valid = held ? buf_valid : imem_valid;

endmodule

//--- design/inst_decoder.sv
// rv32i base decoder, builds execute control and register indices, applies flush
`timescale 1ns/1ps

module inst_decoder (
	input  logic                     slot_valid,
	input  logic [idu_pkg::xlen-1:0] inst,
	input  logic                     inst_valid,
	input  logic                     flush,
	output idu_pkg::ex_ctrl_t        ctrl,
	output idu_pkg::reg_idx_t        regs,
	output logic [idu_pkg::xlen-1:0] out_inst,
	output logic                     out_valid,
	output logic                     uses_rs2
);

	idu_pkg::opcode_t opcode;
	logic [2:0]       funct3;
	logic             f7_alt;

	logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
	logic is_load, is_store, is_imm, is_reg, is_fence;

	idu_pkg::alu_op_t   alu_op;
	idu_pkg::mem_size_t mem_size;

	assign opcode = inst[6:2];
	assign funct3 = inst[14:12];
	// funct7 bit 5 selects sub and sra
	assign f7_alt = inst[30];

	// nothing decodes while the slot is empty
	assign is_lui    = slot_valid && (opcode == idu_pkg::op_lui);
	assign is_auipc  = slot_valid && (opcode == idu_pkg::op_auipc);
	assign is_jal    = slot_valid && (opcode == idu_pkg::op_jal);
	assign is_jalr   = slot_valid && (opcode == idu_pkg::op_jalr);
	assign is_branch = slot_valid && (opcode == idu_pkg::op_branch);
	assign is_load   = slot_valid && (opcode == idu_pkg::op_load);
	assign is_store  = slot_valid && (opcode == idu_pkg::op_store);
	assign is_imm    = slot_valid && (opcode == idu_pkg::op_imm);
	assign is_reg    = slot_valid && (opcode == idu_pkg::op_reg);
	assign is_fence  = slot_valid && (opcode == idu_pkg::op_fence);

	always_comb begin
		alu_op = idu_pkg::alu_add;
		if (is_branch) begin
			case (funct3)
				idu_pkg::f3_beq:  alu_op = idu_pkg::alu_seq;
				idu_pkg::f3_bne:  alu_op = idu_pkg::alu_sne;
				idu_pkg::f3_blt:  alu_op = idu_pkg::alu_slt;
				idu_pkg::f3_bge:  alu_op = idu_pkg::alu_sge;
				idu_pkg::f3_bltu: alu_op = idu_pkg::alu_sltu;
				idu_pkg::f3_bgeu: alu_op = idu_pkg::alu_sgeu;
				default:          alu_op = idu_pkg::alu_add;
			endcase
		end else if (is_imm || is_reg) begin
			case (funct3)
				idu_pkg::f3_add:  alu_op = (is_reg && f7_alt) ? idu_pkg::alu_sub : idu_pkg::alu_add;
				idu_pkg::f3_sll:  alu_op = idu_pkg::alu_sll;
				idu_pkg::f3_slt:  alu_op = idu_pkg::alu_slt;
				idu_pkg::f3_sltu: alu_op = idu_pkg::alu_sltu;
				idu_pkg::f3_xor:  alu_op = idu_pkg::alu_xor;
				// srai carries the same bit 30 as sra
				idu_pkg::f3_srl:  alu_op = f7_alt ? idu_pkg::alu_sra : idu_pkg::alu_srl;
				idu_pkg::f3_or:   alu_op = idu_pkg::alu_or;
				default:          alu_op = idu_pkg::alu_and;
			endcase
		end
	end

	always_comb begin
		mem_size = idu_pkg::size_byte_s;
		if (is_load || is_store) begin
			case (funct3)
				idu_pkg::f3_byte_u: mem_size = idu_pkg::size_byte_u;
				idu_pkg::f3_half:   mem_size = idu_pkg::size_half_s;
				idu_pkg::f3_half_u: mem_size = idu_pkg::size_half_u;
				idu_pkg::f3_word:   mem_size = idu_pkg::size_word;
				default:            mem_size = idu_pkg::size_byte_s;
			endcase
		end
	end

	always_comb begin
		ctrl.rf_we       = !flush && (is_lui || is_auipc || is_jal || is_jalr
			|| is_load || is_imm || is_reg);
		ctrl.wb_sel      = is_lui ? idu_pkg::wb_upper :
			(is_jal || is_jalr) ? idu_pkg::wb_link : idu_pkg::wb_alu;
		ctrl.wb_from_mem = is_load;
		ctrl.alu_src_imm = is_jalr || is_load || is_store || is_imm;
		ctrl.alu_op      = alu_op;
		ctrl.mem_we      = !flush && is_store;
		ctrl.mem_re      = !flush && is_load;
		ctrl.mem_size    = mem_size;
		ctrl.branch      = !flush && is_branch;
		ctrl.jump        = !flush && (is_jal || is_jalr);
		ctrl.jump_reg    = is_jalr;
	end

	assign regs.rs1 = inst[19:15];
	assign regs.rs2 = inst[24:20];
	assign regs.rd  = inst[11:7];

	assign uses_rs2  = is_branch || is_reg;
	// fence needs no ordering here, it goes down as a nop
	assign out_inst  = (flush || is_fence) ? idu_pkg::nop_inst : inst;
	assign out_valid = slot_valid && inst_valid && !flush;

endmodule

//--- design/load_use_hazard.sv
// load-use and missing-instruction hazard detection for the decode slot
`timescale 1ns/1ps

module load_use_hazard (
	input  logic                           slot_valid,
	input  logic                           inst_valid,
	input  logic                           ex_mem_re,
	input  logic                           uses_rs2,
	input  logic [idu_pkg::reg_addr_w-1:0] ex_rd,
	input  idu_pkg::reg_idx_t              regs,
	output logic                           hazard
);

	logic rs1_hit;
	logic rs2_hit;
	logic load_use;
	logic no_word;

	assign rs1_hit = (ex_rd == regs.rs1);
	// immediate ops have no rs2, their field is part of the immediate
	assign rs2_hit = uses_rs2 && (ex_rd == regs.rs2);

	assign load_use = slot_valid && ex_mem_re && (rs1_hit || rs2_hit);
	// slot holds a pc but imem has not answered
	assign no_word  = slot_valid && !inst_valid;

	assign hazard = load_use || no_word;

endmodule

//--- sources.f
design/idu_pkg.sv
design/id_pipe_reg.sv
design/inst_buffer.sv
design/inst_decoder.sv
design/imm_gen.sv
design/load_use_hazard.sv
design/idu_top.sv
testbench/idu_sva.sv
testbench/idu_tb.sv

//--- testbench/idu_sva.sv
// port-level concurrent checks on the decode stage, bound into every idu_top instance
`timescale 1ns/1ps

module idu_sva (
	input logic                           clk,
	input logic                           rstn,
	input logic                           stall,
	input logic                           flush,
	input logic                           ex_mem_re,
	input logic [idu_pkg::reg_addr_w-1:0] ex_rd,
	input logic                           id_valid,
	input logic [idu_pkg::xlen-1:0]       id_pc,
	input logic [idu_pkg::xlen-1:0]       id_inst,
	input idu_pkg::reg_idx_t              id_regs,
	input idu_pkg::ex_ctrl_t              id_ctrl,
	input logic                           hazard
);

	int fail_count = 0;

	// a flushed slot sends nothing into execute
	flush_kills: assert property (@(posedge clk) disable iff (!rstn)
		flush |-> !id_valid && !id_ctrl.rf_we && !id_ctrl.mem_we && !id_ctrl.mem_re
			&& !id_ctrl.branch && !id_ctrl.jump && id_inst == idu_pkg::nop_inst)
		else begin
			fail_count++;
			$error("flush left the slot live or id_inst not a nop");
		end

	// frozen slot keeps pc and word
	stall_holds: assert property (@(posedge clk) disable iff (!rstn)
		stall && id_valid && !flush |=> $stable(id_pc) && (flush || $stable(id_inst)))
		else begin
			fail_count++;
			$error("id_pc or id_inst moved during a stall");
		end

	load_use: assert property (@(posedge clk) disable iff (!rstn)
		id_valid && ex_mem_re && ex_rd == id_regs.rs1 |-> hazard)
		else begin
			fail_count++;
			$error("load into rs1 without a hazard");
		end

endmodule

bind idu_top idu_sva u_sva (.*);

//--- testbench/idu_tb.sv
// testbench for the decode stage, directed and random decode tests with per-test reporting
`timescale 1ns/1ps

module idu_tb;

	localparam int num_rand    = 20;
	// reset and idle, two cycles per decoded word, stall sequence
	localparam int stim_cycles = 8 + 2 * (5 + 5 + num_rand + 2 + 3) + 10;
	localparam int max_cycles  = stim_cycles + 50;

	localparam logic [31:0] w_add  = 32'h0020_81b3;
	localparam logic [31:0] w_sub  = 32'h4020_81b3;
	localparam logic [31:0] w_slti = 32'hffd3_2293;
	localparam logic [31:0] w_bltu = 32'h0020_e463;
	localparam logic [31:0] w_addi = 32'h0050_0093;
	localparam logic [31:0] w_lhu  = 32'h0041_5383;

	logic                 clk = 1'b0;
	logic                 rstn;
	idu_pkg::fetch_info_t if_info;
	logic                 imem_valid;
	logic [31:0]          imem_data;
	logic                 stall;
	logic                 flush;
	logic                 ex_mem_re;
	logic [4:0]           ex_rd;
	logic                 id_valid;
	logic [31:0]          id_pc;
	logic [31:0]          id_pc_plus;
	logic [31:0]          id_inst;
	idu_pkg::reg_idx_t    id_regs;
	idu_pkg::ex_ctrl_t    id_ctrl;
	logic [31:0]          id_imm;
	logic                 hazard;

	integer      seed;
	int          errors = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;
	logic [31:0] next_pc;
	logic [31:0] held_pc;
	logic [31:0] held_inst;
	logic [31:0] word;
	logic [6:0]  imm_ops [5] = '{7'b0010011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b0110111};

	idu_top u_idu_top (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run went past %0d cycles", max_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			test_errs++;
			$display("[ERROR] %0t ns: %s", $time, what);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %-10s %s, %0d mismatches", name, (test_errs == 0) ? "passed" : "failed",
			test_errs);
		test_errs = 0;
	endtask

	task automatic expect_idle(input string when);
		check(!id_valid && !hazard && !id_ctrl.rf_we && !id_ctrl.mem_we && !id_ctrl.mem_re
			&& !id_ctrl.branch && !id_ctrl.jump, {"outputs not quiet ", when});
	endtask

	// fetch presents the pc, imem answers a cycle later, then sample mid-cycle
	task automatic decode_one(input logic [31:0] w, input logic fl, input logic ld,
		input logic [4:0] rd);
		@(posedge clk);
		if_info    <= '{valid: 1'b1, pc: next_pc, pc_plus: next_pc + 32'd4};
		imem_valid <= 1'b0;
		@(posedge clk);
		if_info.valid <= 1'b0;
		imem_valid    <= 1'b1;
		imem_data     <= w;
		flush         <= fl;
		ex_mem_re     <= ld;
		ex_rd         <= rd;
		@(negedge clk);
		next_pc = next_pc + 32'd4;
	endtask

	// immediate by format, straight from the base isa field layout
	function automatic logic [31:0] exp_imm(input logic [31:0] w);
		logic [31:0] v;
		case (w[6:0])
			7'b1100111, 7'b0000011, 7'b0010011: v = {{20{w[31]}}, w[31:20]};
			7'b0100011: v = {{20{w[31]}}, w[31:25], w[11:7]};
			7'b1100011: v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			7'b1101111: v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default:    v = {w[31:12], 12'h000};
		endcase
		return v;
	endfunction

	initial begin
		seed       = 32'h1373c8a4;
		rstn       = 1'b0;
		if_info    = '0;
		imem_valid = 1'b0;
		imem_data  = '0;
		stall      = 1'b0;
		flush      = 1'b0;
		ex_mem_re  = 1'b0;
		ex_rd      = '0;
		next_pc    = 32'h0000_1000;

		repeat (4) @(posedge clk);
		@(negedge clk);
		expect_idle("in reset");
		@(posedge clk);
		rstn <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			expect_idle("after reset");
		end
		end_test("reset");

		decode_one(w_sub, 1'b0, 1'b0, 5'd0);
		check(id_valid && id_ctrl.alu_op == idu_pkg::alu_sub && id_ctrl.rf_we
			&& !id_ctrl.alu_src_imm, "sub decode");
		check(id_regs.rs1 == 5'd1 && id_regs.rs2 == 5'd2 && id_regs.rd == 5'd3,
			$sformatf("sub register indices %h", id_regs));
		decode_one(w_slti, 1'b0, 1'b0, 5'd0);
		check(id_ctrl.alu_op == idu_pkg::alu_slt && id_ctrl.alu_src_imm, "slti decode");
		decode_one(w_bltu, 1'b0, 1'b0, 5'd0);
		check(id_ctrl.alu_op == idu_pkg::alu_sltu && id_ctrl.branch && !id_ctrl.rf_we,
			"bltu decode");
		decode_one(w_addi, 1'b0, 1'b0, 5'd0);
		check(id_ctrl.alu_src_imm && id_ctrl.rf_we && id_ctrl.alu_op == idu_pkg::alu_add,
			"addi decode");
		decode_one(w_lhu, 1'b0, 1'b0, 5'd0);
		check(id_ctrl.mem_re && id_ctrl.wb_from_mem && id_ctrl.rf_we
			&& id_ctrl.mem_size == idu_pkg::size_half_u, "lhu decode");
		end_test("alu");

		// directed I, S, B, J, U words first, then random ones
		for (int i = 0; i < 5 + num_rand; i++) begin
			case (i)
				0: word = w_slti;
				1: word = 32'hfe20_ac23;
				2: word = 32'hfe20_8ee3;
				3: word = 32'hff5f_f0ef;
				4: word = 32'h1234_50b7;
				default: begin
					word      = $random(seed);
					word[6:0] = imm_ops[i % 5];
				end
			endcase
			decode_one(word, 1'b0, 1'b0, 5'd0);
			check(id_imm == exp_imm(word), $sformatf("imm of %h is %h, expected %h",
				word, id_imm, exp_imm(word)));
			if (i == 3)
				check(id_ctrl.jump && !id_ctrl.jump_reg && id_ctrl.wb_sel == idu_pkg::wb_link,
					"jal control");
			if (i == 4)
				check(id_ctrl.rf_we && id_ctrl.wb_sel == idu_pkg::wb_upper, "lui control");
		end
		end_test("imm");

		decode_one(w_add, 1'b1, 1'b0, 5'd0);
		check(!id_valid && !id_ctrl.rf_we && !id_ctrl.mem_we && !id_ctrl.mem_re
			&& !id_ctrl.branch && !id_ctrl.jump, "flush left enables high");
		check(id_inst == idu_pkg::nop_inst, $sformatf("flushed id_inst is %h", id_inst));
		decode_one(32'h0ff0_000f, 1'b0, 1'b0, 5'd0);
		check(id_valid && id_inst == idu_pkg::nop_inst,
			$sformatf("fence gave id_inst %h, id_valid %b", id_inst, id_valid));
		end_test("flush");

		// stall rises with the slot valid and imem answering
		@(posedge clk);
		if_info    <= '{valid: 1'b1, pc: next_pc, pc_plus: next_pc + 32'd4};
		imem_valid <= 1'b0;
		@(posedge clk);
		if_info    <= '{valid: 1'b1, pc: next_pc + 32'd4, pc_plus: next_pc + 32'd8};
		imem_valid <= 1'b1;
		imem_data  <= w_addi;
		stall      <= 1'b1;
		@(negedge clk);
		held_pc   = id_pc;
		held_inst = id_inst;
		check(held_pc == next_pc && id_pc_plus == next_pc + 32'd4 && held_inst == w_addi,
			"stalled slot has wrong pc, pc_plus or word");
		repeat (4) begin
			@(posedge clk);
			imem_data <= $random(seed);
			@(negedge clk);
			check(id_pc == held_pc && id_inst == held_inst,
				$sformatf("during stall pc %h inst %h", id_pc, id_inst));
		end
		@(posedge clk);
		stall     <= 1'b0;
		imem_data <= $random(seed);
		@(negedge clk);
		check(id_pc == held_pc && id_inst == held_inst, "replay lost as stall fell");
		@(posedge clk);
		if_info.valid <= 1'b0;
		imem_data     <= w_add;
		@(negedge clk);
		check(id_valid && id_pc == next_pc + 32'd4 && id_inst == w_add && id_ctrl.rf_we
			&& id_ctrl.alu_op == idu_pkg::alu_add,
			$sformatf("after stall pc %h inst %h", id_pc, id_inst));
		next_pc = next_pc + 32'd8;
		end_test("stall");

		decode_one(w_add, 1'b0, 1'b1, 5'd1);
		check(hazard, "no hazard on a load into rs1");
		decode_one(w_bltu, 1'b0, 1'b1, 5'd2);
		check(hazard, "no hazard on a load into rs2 of a branch");
		// rs2 field of addi x5,x6,2 is immediate bits
		decode_one(32'h0023_0293, 1'b0, 1'b1, 5'd2);
		check(!hazard, "hazard raised on the rs2 field of an immediate op");
		end_test("hazard");

		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, u_idu_top.u_sva.fail_count);
		if (errors == 0 && u_idu_top.u_sva.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
